//--- sim/mem_tb_vectors.txt
# Columns: name we width(0 byte, 1 halfword, 2 word) sign_extend addr(hex) wdata(hex) expected(hex)
# Expected read data applies to loads only; stores carry 0 there.
w_word0     1 2 0 000 11223344 0
w_word4     1 2 0 004 55667788 0
w_word8     1 2 0 008 99aabbcc 0
r_word8     0 2 0 008 00000000 99aabbcc
r_word0     0 2 0 000 00000000 11223344
r_word4     0 2 0 004 00000000 55667788
w_base10    1 2 0 010 00000000 0
w_byte11    1 0 0 011 000000a5 0
w_byte12    1 0 0 012 ffffff3c 0
r_word10a   0 2 0 010 00000000 003ca500
w_byte10    1 0 0 010 00000077 0
w_byte13    1 0 0 013 12345681 0
r_word10b   0 2 0 010 00000000 813ca577
w_base20    1 2 0 020 ffffffff 0
w_half21    1 1 0 021 abcd1234 0
r_word20a   0 2 0 020 00000000 ff1234ff
w_half20    1 1 0 020 00005a6b 0
w_half22    1 1 0 022 0000c3d2 0
r_word20b   0 2 0 020 00000000 c3d25a6b
r_byte23_s  0 0 1 023 00000000 ffffffc3
r_byte23_u  0 0 0 023 00000000 000000c3
r_byte20_s  0 0 1 020 00000000 0000006b
r_half22_s  0 1 1 022 00000000 ffffc3d2
r_half22_u  0 1 0 022 00000000 0000c3d2
r_half20_s  0 1 1 020 00000000 00005a6b
r_half21_s  0 1 1 021 00000000 ffffd25a
r_byte11_u  0 0 0 011 00000000 000000a5
w_word41    1 2 0 041 a1b2c3d4 0
w_word46    1 2 0 046 0badf00d 0
w_word4b    1 2 0 04b 13579bdf 0
w_half4f    1 1 0 04f 00008e7f 0
r_word41    0 2 0 041 00000000 a1b2c3d4
r_word46    0 2 0 046 00000000 0badf00d
r_word4b    0 2 0 04b 00000000 13579bdf
r_half4f_s  0 1 1 04f 00000000 ffff8e7f
r_word4c    0 2 0 04c 00000000 7f13579b
w_word3fc   1 2 0 3fc 01020304 0
r_word3fc   0 2 0 3fc 00000000 01020304
w_word3fd   1 2 0 3fd cafef00d 0
r_word3fd   0 2 0 3fd 00000000 cafef00d
w_word3fe   1 2 0 3fe 89abcdef 0
r_word3fe   0 2 0 3fe 00000000 89abcdef
r_word0_wrap 0 2 0 000 00000000 112289ab
r_word3fc_b 0 2 0 3fc 00000000 cdef0d04

//--- project.f
source/mem_pkg.sv
source/spram_block.sv
source/d_mem_spram.sv
source/mem_req_port.sv
source/mem_subsystem.sv
sim/mem_tb.sv

//--- Bender.yml
package:
  name: mem_subsystem

# RTL sources in compile order.
sources:
  - source/mem_pkg.sv
  - source/spram_block.sv
  - source/d_mem_spram.sv
  - source/mem_req_port.sv
  - source/mem_subsystem.sv

  # Testbench, only for simulation.
  - target: simulation
    files:
      - sim/mem_tb.sv

export_include_dirs: []

dependencies: {}

//--- sim/mem_tb.sv
// Data memory testbench
module mem_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import mem_pkg::*;

  logic        clk;
  logic        reset;
  logic        req;
  logic        we;
  mem_width_t  width;
  logic        sign_extend;
  logic [9:0]  addr;
  logic [31:0] wdata;
  logic        ack;
  logic [31:0] rdata;

  string       vec_name[$];
  int          vec_we[$];
  int          vec_width[$];
  int          vec_sign[$];
  logic [31:0] vec_addr[$];
  logic [31:0] vec_wdata[$];
  logic [31:0] vec_expected[$];

  int cycle_count = 0;
  int cycle_limit = 0;

  mem_subsystem #(
    .addr_width(10)
  ) mem_subsystem_inst (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .we         (we),
    .width      (width),
    .sign_extend(sign_extend),
    .addr       (addr),
    .wdata      (wdata),
    .ack        (ack),
    .rdata      (rdata)
  );

  always #10 clk = ~clk;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      stop_with_failure("Timeout: the run went past its cycle limit without finishing.");
    end
  end

  // Lines that start with # are comments. Blank lines are skipped.
  task automatic load_vectors();
    int          fd;
    int          fields;
    string       line;
    string       name;
    int          we_v;
    int          width_v;
    int          sign_v;
    logic [31:0] addr_v;
    logic [31:0] wdata_v;
    logic [31:0] exp_v;
    fd = $fopen("sim/mem_tb_vectors.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Could not open the vector file sim/mem_tb_vectors.txt.");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#") begin
        fields = $sscanf(line, "%s %d %d %d %h %h %h", name, we_v, width_v, sign_v,
                         addr_v, wdata_v, exp_v);
        if (fields == 7) begin
          vec_name.push_back(name);
          vec_we.push_back(we_v);
          vec_width.push_back(width_v);
          vec_sign.push_back(sign_v);
          vec_addr.push_back(addr_v);
          vec_wdata.push_back(wdata_v);
          vec_expected.push_back(exp_v);
        end else if (fields > 0) begin
          stop_with_failure($sformatf("Malformed line in the vector file: %s", line));
        end
      end
    end
    $fclose(fd);
  endtask

  // One full four-phase transfer, driven on falling edges.
  task automatic run_access(input int index);
    int          edges;
    logic [31:0] held;
    we          = (vec_we[index] != 0);
    width       = mem_width_t'(vec_width[index]);
    sign_extend = (vec_sign[index] != 0);
    addr        = vec_addr[index][9:0];
    wdata       = vec_wdata[index];
    req         = 1'b1;
    edges = 0;
    do begin
      @(negedge clk);
      edges++;
    end while (ack !== 1'b1);
    assert (edges == 3) else
      stop_with_failure($sformatf("FAIL %s ack delay expected %0d actual %0d",
                                  vec_name[index], 3, edges));
    if (vec_we[index] == 0) begin
      assert (rdata === vec_expected[index]) else
        stop_with_failure($sformatf("FAIL %s expected %h actual %h",
                                    vec_name[index], vec_expected[index], rdata));
    end
    // Some transfers keep req high a little longer.
    if (index % 4 == 3) begin
      held = rdata;
      repeat (2) begin
        @(negedge clk);
        assert (ack === 1'b1) else
          stop_with_failure($sformatf("ack dropped while req was still high in %s.",
                                      vec_name[index]));
        assert (rdata === held) else
          stop_with_failure($sformatf("FAIL %s held rdata expected %h actual %h",
                                      vec_name[index], held, rdata));
      end
    end
    req = 1'b0;
    @(negedge clk);
    assert (ack === 1'b0) else
      stop_with_failure($sformatf("ack stayed high after req dropped in %s.", vec_name[index]));
  endtask

  initial begin
    int gap;
    clk         = 1'b0;
    reset       = 1'b1;
    req         = 1'b0;
    we          = 1'b0;
    width       = WORD;
    sign_extend = 1'b0;
    addr        = '0;
    wdata       = '0;
    void'($urandom(32'hbcc5));
    load_vectors();
    cycle_limit = vec_name.size() * 10 + 20; // Reset and idle cycles fit in the margin.
    repeat (5) begin
      @(negedge clk);
      assert (ack === 1'b0) else stop_with_failure("ack was high during reset.");
    end
    reset = 1'b0;
    repeat (2) begin
      @(negedge clk);
      assert (ack === 1'b0) else stop_with_failure("ack rose with no request pending.");
    end
    for (int i = 0; i < vec_name.size(); i++) begin
      run_access(i);
      gap = $urandom % 4;
      repeat (gap) @(negedge clk);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- source/mem_subsystem.sv
// Data memory subsystem
module mem_subsystem #(
  parameter int addr_width = 10
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  logic                  we,
  input  mem_pkg::mem_width_t   width,
  input  logic                  sign_extend,
  input  logic [addr_width-1:0] addr,
  input  logic [31:0]           wdata,
  output logic                  ack,
  output logic [31:0]           rdata
);
  import mem_pkg::*;

  logic                  mem_write_enable;
  mem_width_t            mem_width;
  logic                  mem_sign_extend;
  logic [addr_width-1:0] mem_addr;
  logic [31:0]           mem_wdata;
  logic [31:0]           mem_rdata;

  mem_req_port #(
    .addr_width(addr_width)
  ) mem_req_port_inst (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .we              (we),
    .width           (width),
    .sign_extend     (sign_extend),
    .addr            (addr),
    .wdata           (wdata),
    .ack             (ack),
    .rdata           (rdata),
    .mem_write_enable(mem_write_enable),
    .mem_width       (mem_width),
    .mem_sign_extend (mem_sign_extend),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .mem_rdata       (mem_rdata)
  );

  d_mem_spram #(
    .addr_width(addr_width)
  ) d_mem_spram_inst (
    .clk         (clk),
    .reset       (reset),
    .width       (mem_width),
    .sign_extend (mem_sign_extend),
    .addr        (mem_addr),
    .data_in     (mem_wdata),
    .write_enable(mem_write_enable),
    .data_out    (mem_rdata)
  );

endmodule

//--- source/mem_req_port.sv
// Four-phase request port
module mem_req_port #(
  parameter int addr_width = 10
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  logic                  we,
  input  mem_pkg::mem_width_t   width,
  input  logic                  sign_extend,
  input  logic [addr_width-1:0] addr,
  input  logic [31:0]           wdata,
  output logic                  ack,
  output logic [31:0]           rdata,
  output logic                  mem_write_enable,
  output mem_pkg::mem_width_t   mem_width,
  output logic                  mem_sign_extend,
  output logic [addr_width-1:0] mem_addr,
  output logic [31:0]           mem_wdata,
  input  logic [31:0]           mem_rdata
);
  import mem_pkg::*;

  port_state_t state;
  port_state_t state_next;
  logic        we_q;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req) begin
          state_next = ACCESS;
        end
      end
      ACCESS:  state_next = CAPTURE;
      CAPTURE: state_next = DONE;
      DONE: begin
        // Hold here until the requester has seen ack and let go of req.
        if (!req) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // The request is taken once when it is accepted, so the banks see a
  // steady access for the whole transfer.
  always_ff @(posedge clk) begin
    if (state == IDLE && req) begin
      we_q            <= we;
      mem_width       <= width;
      mem_sign_extend <= sign_extend;
      mem_addr        <= addr;
      mem_wdata       <= wdata;
    end
  end

  // Memory output in CAPTURE belongs to the access of the previous cycle.
  always_ff @(posedge clk) begin
    if (reset) begin
      rdata <= 32'h00000000;
    end else if (state == CAPTURE) begin
      rdata <= mem_rdata;
    end
  end

  assign mem_write_enable = (state == ACCESS) && we_q; // One cycle per store.
  assign ack              = (state == DONE);

endmodule

//--- source/d_mem_spram.sv
// Byte-lane data memory
module d_mem_spram #(
  parameter int addr_width = 10
) (
  input  logic                  clk,
  input  logic                  reset,
  input  mem_pkg::mem_width_t   width,
  input  logic                  sign_extend,
  input  logic [addr_width-1:0] addr,
  input  logic [31:0]           data_in,
  input  logic                  write_enable,
  output logic [31:0]           data_out
);
  import mem_pkg::*;

  localparam int row_width = addr_width - 2;

  logic [1:0]                offset;
  logic [row_width-1:0]      row;
  logic [row_width-1:0]      next_row;
  logic [2:0]                lane_count;
  logic [3:0][1:0]           bank_lane;
  logic [3:0][row_width-1:0] bank_row;
  logic [3:0][7:0]           bank_din;
  logic [3:0]                bank_we;
  logic [3:0][7:0]           bank_dout;
  logic [1:0]                offset_q;
  mem_width_t                width_q;
  logic                      sign_extend_q;
  logic [31:0]               aligned;

  assign offset   = addr[1:0];
  assign row      = addr[addr_width-1:2];
  assign next_row = row + 1'b1; // Rolls over to row zero at the top of memory.

  // Each bank serves one byte of the access. The lane number is the byte
  // position inside the access word, counted from the start offset.
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      bank_lane[b] = 2'(b) - offset;
    end
  end

  // Banks below the offset hold the bytes that spill into the next row.
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      if (2'(b) < offset) begin
        bank_row[b] = next_row;
      end else begin
        bank_row[b] = row;
      end
    end
  end

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      bank_din[b] = data_in[8*bank_lane[b] +: 8];
    end
  end

  always_comb begin
    case (width)
      BYTE:     lane_count = 3'd1;
      HALFWORD: lane_count = 3'd2;
      WORD:     lane_count = 3'd4;
      default:  lane_count = 3'd0; // Unused code writes nothing.
    endcase
  end

  // A bank is written only when its lane lies inside the access.
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      bank_we[b] = write_enable && ({1'b0, bank_lane[b]} < lane_count);
    end
  end

  for (genvar g = 0; g < 4; g++) begin : g_bank
    spram_block #(
      .row_width(row_width)
    ) bank (
      .clk         (clk),
      .reset       (reset),
      .address     (bank_row[g]),
      .write_enable(bank_we[g]),
      .data_in     (bank_din[g]),
      .data_out    (bank_dout[g])
    );
  end

  // Bank outputs arrive one cycle late, so the shape of the access is kept
  // alongside them.
  always_ff @(posedge clk) begin
    if (reset) begin
      offset_q      <= 2'd0;
      width_q       <= WORD;
      sign_extend_q <= 1'b0;
    end else begin
      offset_q      <= offset;
      width_q       <= width;
      sign_extend_q <= sign_extend;
    end
  end

  // Read byte i comes from bank (offset + i) mod 4.
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      aligned[8*i +: 8] = bank_dout[2'(2'(i) + offset_q)];
    end
  end

  always_comb begin
    case (width_q)
      BYTE: begin
        if (sign_extend_q) begin
          data_out = {{24{aligned[7]}}, aligned[7:0]};
        end else begin
          data_out = {24'h000000, aligned[7:0]};
        end
      end
      HALFWORD: begin
        if (sign_extend_q) begin
          data_out = {{16{aligned[15]}}, aligned[15:0]};
        end else begin
          data_out = {16'h0000, aligned[15:0]};
        end
      end
      default: begin
        data_out = aligned; // Full word, nothing to extend.
      end
    endcase
  end

endmodule

//--- source/spram_block.sv
// Byte-wide RAM bank
module spram_block #(
  parameter int row_width = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [row_width-1:0] address,
  input  logic                 write_enable,
  input  logic [7:0]           data_in,
  output logic [7:0]           data_out
);

  localparam int depth = 2 ** row_width;

  logic [7:0] mem [depth];

  always_ff @(posedge clk) begin
    if (write_enable) begin
      mem[address] <= data_in;
    end
  end

  // The read register sees the old contents on a write to the same row.
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= 8'h00;
    end else begin
      data_out <= mem[address];
    end
  end

endmodule

//--- source/mem_pkg.sv
// Data memory types
package mem_pkg;

  // Access size of one request.
  typedef enum logic [1:0] {
    BYTE     = 2'b00,
    HALFWORD = 2'b01,
    WORD     = 2'b10
  } mem_width_t;

  // Request controller states. One access is in flight at a time.
  typedef enum logic [1:0] {
    IDLE    = 2'b00, // Waiting for req.
    ACCESS  = 2'b01, // Address and write enable go to the banks.
    CAPTURE = 2'b10, // Realigned read data is registered.
    DONE    = 2'b11  // ack is high until req drops.
  } port_state_t;

endpackage
